// ==== rtl/image_geometry.sv ====
/*
 * image geometry
 * holds the segment config registers, loads them on next and derives
 * the padded area, the image edges and the last launch position
 */
`timescale 1ns/1ps

module image_geometry (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cfg_valid,
    input  logic [image_read_pkg::CFG_AWIDTH-1:0] cfg_addr,
    input  logic [image_read_pkg::CFG_DWIDTH-1:0] cfg_data,
    input  logic                                 next,
    input  logic                                 busy,
    output logic                                 go,
    output image_read_pkg::coord_t               img_w,
    output image_read_pkg::coord_t               img_h,
    output image_read_pkg::coord_t               img_d,
    output image_read_pkg::coord_t               conv_side,
    output image_read_pkg::coord_t               conv_step,
    output image_read_pkg::coord_t               edge_l,
    output image_read_pkg::coord_t               edge_t,
    output image_read_pkg::coord_t               edge_r,
    output image_read_pkg::coord_t               edge_b,
    output image_read_pkg::coord_t               area_w_max,
    output image_read_pkg::coord_t               area_h_max
);
    import image_read_pkg::*;

    cfg_word_u cfg_w;                    // incoming word viewed per address
    coord_t cfg_img_w;                   // image width - 1
    cfg_word_u cfg_dh, cfg_pad, cfg_conv;
    logic   next_ok;                     // next accepted only when idle
    logic   next_1p, next_2p;
    coord_t pad_l, pad_r, pad_t, pad_b;
    coord_t maxp_side;
    coord_t area_w, area_h;              // image plus padding

    assign cfg_w   = cfg_data;
    assign next_ok = next & ~busy;

    // config registers with one field layout per address
    always_ff @(posedge clk) begin
        if (cfg_valid) begin
            case (cfg_addr)
                cfg_ir_img_w:  cfg_img_w <= cfg_data[15:0];
                cfg_ir_img_dh: cfg_dh    <= cfg_w;
                cfg_ir_pad:    cfg_pad   <= cfg_w;
                cfg_ir_conv:   cfg_conv  <= cfg_w;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_1p <= 1'b0;
            next_2p <= 1'b0;
            go      <= 1'b0;
        end else begin
            next_1p <= next_ok;
            next_2p <= next_1p;
            go      <= next_2p;  // constraints settled
        end
    end

    // stage 1 latches the config and adds 1 to zero indexed values
    always_ff @(posedge clk) begin
        if (next_ok) begin
            img_w     <= cfg_img_w + 16'd1;
            img_h     <= cfg_dh.dh.h + 16'd1;
            img_d     <= cfg_dh.dh.d + 16'd1;
            pad_l     <= {8'd0, cfg_pad.pad.l};
            pad_r     <= {8'd0, cfg_pad.pad.r};
            pad_t     <= {8'd0, cfg_pad.pad.t};
            pad_b     <= {8'd0, cfg_pad.pad.b};
            maxp_side <= {8'd0, cfg_conv.conv.maxp_side};
            conv_side <= {8'd0, cfg_conv.conv.conv_side} + 16'd1;  // 0 is a 1x1 conv
            conv_step <= cfg_conv.conv.conv_step + 16'd1;         // 0 is a 1 pixel step
        end
    end

    // stage 2 derives the padded area and the image edges
    always_ff @(posedge clk) begin
        area_w <= pad_l + img_w + pad_r;
        area_h <= pad_t + img_h + pad_b;
        edge_l <= pad_l;
        edge_t <= pad_t;
        edge_r <= pad_l + img_w - 16'd1;  // last image column in the area
        edge_b <= pad_t + img_h - 16'd1;
    end

    // stage 3 finds the last position a full conv plus maxpool launches from
    always_ff @(posedge clk) begin
        area_w_max <= area_w - 16'(maxp_side * conv_step) - conv_side;
        area_h_max <= area_h - 16'(maxp_side * conv_step) - conv_side;
    end

endmodule

// ==== rtl/image_mem.sv ====
/*
 * image memory
 * word wide array with a load port and a fixed latency read pipeline
 */
`timescale 1ns/1ps

module image_mem #(
    parameter int GROUP_NB   = 4,
    parameter int IMG_WIDTH  = 16,
    parameter int MEM_AWIDTH = 10,
    parameter int RD_LATENCY = 3
) (
    input  logic                          clk,
    input  logic                          rd_val,
    input  logic [MEM_AWIDTH-1:0]         rd_addr,
    input  logic                          ld_en,
    input  logic [MEM_AWIDTH-1:0]         ld_addr,
    input  logic [GROUP_NB*IMG_WIDTH-1:0] ld_data,
    output logic [GROUP_NB*IMG_WIDTH-1:0] rd_data
);

    logic [GROUP_NB*IMG_WIDTH-1:0] mem [2**MEM_AWIDTH];
    logic [GROUP_NB*IMG_WIDTH-1:0] rd_pipe [RD_LATENCY];  // stage 0 is the array read

    always_ff @(posedge clk) begin
        if (ld_en)
            mem[ld_addr] <= ld_data;
        if (rd_val)
            rd_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < RD_LATENCY; i++)
            rd_pipe[i] <= rd_pipe[i-1];  // extra stages up to RD_LATENCY
    end

    assign rd_data = rd_pipe[RD_LATENCY-1];

endmodule

// ==== rtl/image_read_pkg.sv ====
/*
 * image read package
 * config bus widths and register map, the config word layouts
 * and the default pixel word shape
 */
package image_read_pkg;

    localparam int CFG_DWIDTH = 32;
    localparam int CFG_AWIDTH = 5;

    // config register map
    localparam logic [CFG_AWIDTH-1:0] cfg_ir_img_w  = 5'd0;  // image width - 1
    localparam logic [CFG_AWIDTH-1:0] cfg_ir_img_dh = 5'd1;  // depth - 1, height - 1
    localparam logic [CFG_AWIDTH-1:0] cfg_ir_pad    = 5'd2;  // l, r, t, b paddings
    localparam logic [CFG_AWIDTH-1:0] cfg_ir_conv   = 5'd3;  // maxp side, conv side, step

    // default pixel word shape, overridden from the top level
    localparam int DEF_GROUP_NB  = 4;   // pixels per memory word
    localparam int DEF_IMG_WIDTH = 16;  // bits per pixel

    typedef logic [15:0] coord_t;  // area coordinate

    // one config word, read per register address
    typedef union packed {
        struct packed {
            logic [15:0] d;  // depth - 1
            logic [15:0] h;  // height - 1
        } dh;
        struct packed {
            logic [7:0] l;
            logic [7:0] r;
            logic [7:0] t;
            logic [7:0] b;
        } pad;
        struct packed {
            logic [7:0]  maxp_side;  // extra launch area for a following maxpool
            logic [7:0]  conv_side;  // side - 1
            logic [15:0] conv_step;  // step - 1
        } conv;
    } cfg_word_u;

endpackage

// ==== rtl/image_reader.sv ====
/*
 * image reader top
 * config geometry, window scan, pad and fetch and the image memory,
 * plus the busy flag for one pass
 */
`timescale 1ns/1ps

module image_reader #(
    parameter int GROUP_NB   = image_read_pkg::DEF_GROUP_NB,
    parameter int IMG_WIDTH  = image_read_pkg::DEF_IMG_WIDTH,
    parameter int MEM_AWIDTH = 10,
    parameter int RD_LATENCY = 3,
    parameter int FIFO_DEPTH = 8   // must exceed RD_LATENCY + 2
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  cfg_valid,
    input  logic [image_read_pkg::CFG_AWIDTH-1:0] cfg_addr,
    input  logic [image_read_pkg::CFG_DWIDTH-1:0] cfg_data,
    input  logic                                  next,
    input  logic                                  ld_en,
    input  logic [MEM_AWIDTH-1:0]                 ld_addr,
    input  logic [GROUP_NB*IMG_WIDTH-1:0]         ld_data,
    output logic [GROUP_NB*IMG_WIDTH-1:0]         image_bus,
    output logic                                  image_val,
    output logic                                  image_last,
    input  logic                                  image_rdy,
    output logic                                  busy
);
    import image_read_pkg::*;

    logic   go, room, busy_done;
    coord_t img_w, img_h, img_d, conv_side, conv_step;
    coord_t edge_l, edge_t, edge_r, edge_b;
    coord_t area_w_max, area_h_max;
    logic   px_val, px_last;
    coord_t px_x, px_y, px_d;
    logic   rd_val;
    logic [MEM_AWIDTH-1:0]         rd_addr;
    logic [GROUP_NB*IMG_WIDTH-1:0] rd_data;

    // set on an accepted next, cleared when the last word leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            busy <= 1'b0;
        else if (next && !busy)
            busy <= 1'b1;
        else if (busy_done)
            busy <= 1'b0;
    end

    image_geometry i_geometry (
        .clk, .rst_n, .cfg_valid, .cfg_addr, .cfg_data, .next, .busy,
        .go, .img_w, .img_h, .img_d, .conv_side, .conv_step,
        .edge_l, .edge_t, .edge_r, .edge_b, .area_w_max, .area_h_max
    );

    window_scan i_scan (
        .clk, .rst_n, .go, .room, .area_w_max, .area_h_max, .img_d,
        .conv_side, .conv_step, .px_val, .px_x, .px_y, .px_d, .px_last
    );

    pad_fetch #(
        .GROUP_NB(GROUP_NB), .IMG_WIDTH(IMG_WIDTH), .MEM_AWIDTH(MEM_AWIDTH),
        .RD_LATENCY(RD_LATENCY), .FIFO_DEPTH(FIFO_DEPTH)
    ) i_fetch (
        .clk, .rst_n, .px_val, .px_x, .px_y, .px_d, .px_last,
        .edge_l, .edge_t, .edge_r, .edge_b, .img_w, .img_h, .rd_data, .image_rdy,
        .room, .rd_val, .rd_addr, .image_bus, .image_val, .image_last, .busy_done
    );

    image_mem #(
        .GROUP_NB(GROUP_NB), .IMG_WIDTH(IMG_WIDTH), .MEM_AWIDTH(MEM_AWIDTH),
        .RD_LATENCY(RD_LATENCY)
    ) i_mem (
        .clk, .rd_val, .rd_addr, .ld_en, .ld_addr, .ld_data, .rd_data
    );

endmodule

// ==== rtl/pad_fetch.sv ====
/*
 * pad and fetch
 * reads image words for pixels inside the edges, inserts zero words for
 * padding and streams the results out of a small FIFO with val/rdy
 */
`timescale 1ns/1ps

module pad_fetch #(
    parameter int GROUP_NB   = 4,
    parameter int IMG_WIDTH  = 16,
    parameter int MEM_AWIDTH = 10,
    parameter int RD_LATENCY = 3,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            px_val,
    input  image_read_pkg::coord_t          px_x,
    input  image_read_pkg::coord_t          px_y,
    input  image_read_pkg::coord_t          px_d,
    input  logic                            px_last,
    input  image_read_pkg::coord_t          edge_l,
    input  image_read_pkg::coord_t          edge_t,
    input  image_read_pkg::coord_t          edge_r,
    input  image_read_pkg::coord_t          edge_b,
    input  image_read_pkg::coord_t          img_w,
    input  image_read_pkg::coord_t          img_h,
    input  logic [GROUP_NB*IMG_WIDTH-1:0]   rd_data,
    input  logic                            image_rdy,
    output logic                            room,
    output logic                            rd_val,
    output logic [MEM_AWIDTH-1:0]           rd_addr,
    output logic [GROUP_NB*IMG_WIDTH-1:0]   image_bus,
    output logic                            image_val,
    output logic                            image_last,
    output logic                            busy_done
);
    import image_read_pkg::*;

    localparam int DW = GROUP_NB * IMG_WIDTH;
    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam int PW = $clog2(FIFO_DEPTH);

    logic          is_pad;
    logic [31:0]   addr_full;            // row-major index, depth planes stacked
    logic [RD_LATENCY:0] dl_val, dl_pad, dl_last;  // flags travel with the read
    logic          push, pop;
    logic [DW:0]   fifo_q [FIFO_DEPTH];  // {last, word}
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;
    logic [7:0]    pending;              // FIFO words plus everything in flight

    assign is_pad = (px_x < edge_l) || (px_x > edge_r) || (px_y < edge_t) || (px_y > edge_b);
    assign addr_full = (32'(px_d) * 32'(img_h) + 32'(px_y - edge_t)) * 32'(img_w)
                     + 32'(px_x - edge_l);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_val <= 1'b0;
            dl_val <= '0;
        end else begin
            rd_val <= px_val & ~is_pad;  // padding never touches memory
            dl_val <= {dl_val[RD_LATENCY-1:0], px_val};
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= addr_full[MEM_AWIDTH-1:0];
        dl_pad  <= {dl_pad[RD_LATENCY-1:0], is_pad};
        dl_last <= {dl_last[RD_LATENCY-1:0], px_last};
    end

    // credit back to the scanner, counts the pixel just issued too
    always_comb begin
        pending = 8'(count) + 8'(px_val);
        for (int i = 0; i <= RD_LATENCY; i++)
            pending = pending + 8'(dl_val[i]);
        room = pending < 8'(FIFO_DEPTH - 1);
    end

    assign push = dl_val[RD_LATENCY];  // lines up with rd_data
    assign pop  = image_val & image_rdy;

    always_ff @(posedge clk) begin
        if (push)
            fifo_q[wr_ptr] <= {dl_last[RD_LATENCY], dl_pad[RD_LATENCY] ? '0 : rd_data};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CW'(push) - CW'(pop);
        end
    end

    // head of FIFO drives the bus, it only moves on a transfer
    assign image_val  = (count != '0);
    assign image_bus  = fifo_q[rd_ptr][DW-1:0];
    assign image_last = fifo_q[rd_ptr][DW];
    assign busy_done  = pop & image_last;

endmodule

// ==== rtl/window_scan.sv ====
/*
 * window scanner
 * walks every conv window over the padded area, then depth and kernel
 * pixels, and issues one area coordinate per cycle while room allows
 */
`timescale 1ns/1ps

module window_scan (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   go,
    input  logic                   room,
    input  image_read_pkg::coord_t area_w_max,
    input  image_read_pkg::coord_t area_h_max,
    input  image_read_pkg::coord_t img_d,
    input  image_read_pkg::coord_t conv_side,
    input  image_read_pkg::coord_t conv_step,
    output logic                   px_val,
    output image_read_pkg::coord_t px_x,
    output image_read_pkg::coord_t px_y,
    output image_read_pkg::coord_t px_d,
    output logic                   px_last
);
    import image_read_pkg::*;

    logic   active;                  // pass in progress
    logic   issue;
    coord_t win_x, win_y;            // window start in the area
    coord_t dep;
    coord_t ker_x, ker_y;            // kernel offset
    logic [16:0] win_x_nxt, win_y_nxt;
    logic   kx_end, ky_end, d_end, wx_end, wy_end;
    logic   pass_end;

    assign issue     = active & room;
    assign win_x_nxt = {1'b0, win_x} + {1'b0, conv_step};
    assign win_y_nxt = {1'b0, win_y} + {1'b0, conv_step};

    assign kx_end   = (ker_x == conv_side - 16'd1);
    assign ky_end   = (ker_y == conv_side - 16'd1);
    assign d_end    = (dep == img_d - 16'd1);
    assign wx_end   = (win_x_nxt > {1'b0, area_w_max});  // next step would not fit
    assign wy_end   = (win_y_nxt > {1'b0, area_h_max});
    assign pass_end = kx_end & ky_end & d_end & wx_end & wy_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            px_val <= 1'b0;
            win_x  <= '0;
            win_y  <= '0;
            dep    <= '0;
            ker_x  <= '0;
            ker_y  <= '0;
        end else begin
            px_val <= issue;
            if (go) begin
                active <= 1'b1;
                win_x  <= '0;
                win_y  <= '0;
                dep    <= '0;
                ker_x  <= '0;
                ker_y  <= '0;
            end else if (issue) begin
                if (pass_end)
                    active <= 1'b0;
                // innermost is the kernel column
                if (!kx_end) begin
                    ker_x <= ker_x + 16'd1;
                end else begin
                    ker_x <= '0;
                    if (!ky_end) begin
                        ker_y <= ker_y + 16'd1;
                    end else begin
                        ker_y <= '0;
                        if (!d_end) begin
                            dep <= dep + 16'd1;
                        end else begin
                            dep <= '0;
                            if (!wx_end) begin
                                win_x <= win_x_nxt[15:0];
                            end else begin
                                win_x <= '0;
                                win_y <= win_y_nxt[15:0];  // wraps past the end, unused
                            end
                        end
                    end
                end
            end
        end
    end

    // coordinate of the issued pixel
    always_ff @(posedge clk) begin
        if (issue) begin
            px_x    <= win_x + ker_x;
            px_y    <= win_y + ker_y;
            px_d    <= dep;
            px_last <= pass_end;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the image reader testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_image_reader -o tb_image_reader

# a higher error limit lets assertion failures reach the closing summary
./obj_dir/tb_image_reader +verilator+error+limit+1000 | tee sim.log

if grep -q "TB PASSED" sim.log; then
    echo "simulation ok, see sim.log"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== sim.f ====
rtl/image_read_pkg.sv
rtl/image_geometry.sv
rtl/window_scan.sv
rtl/pad_fetch.sv
rtl/image_mem.sv
rtl/image_reader.sv
test/image_reader_checker.sv
test/image_reader_props.sv
test/tb_image_reader.sv

// ==== test/image_reader_checker.sv ====
/*
 * image reader checker
 * models the expected word stream of one pass and compares every
 * transferred word and last flag at the DUT outputs
 */
`timescale 1ns/1ps

module image_reader_checker #(
    parameter int DW         = 64,
    parameter int MEM_AWIDTH = 10
) (
    input logic          clk,
    input logic          rst_n,
    input logic          image_val,
    input logic          image_rdy,
    input logic          image_last,
    input logic [DW-1:0] image_bus
);

    localparam int MEM_WORDS = 2**MEM_AWIDTH;

    logic [DW-1:0] mem_copy [MEM_WORDS];  // mirror of the loaded image
    logic [DW:0]   exp_q [$];             // {last, word} in stream order
    logic [DW:0]   exp_word;
    int            word_idx;
    int            value_errors = 0;
    int            count_errors = 0;

    task automatic note_word(input int addr, input logic [DW-1:0] data);
        mem_copy[addr] = data;
    endtask

    // windows row-major, then depth, kernel row, kernel column
    task automatic expect_run(input int w, input int h, input int d, input int pl,
                              input int pr, input int pt, input int pb, input int maxp,
                              input int side, input int step, output int words);
        int lx, ly, lwx, lwy;    // last launch limits and last window starts
        int wx, wy, dd, kx, ky;
        int x, y, addr;
        logic pad, last;
        logic [DW-1:0] word;
        lx = pl + w + pr - maxp * step - side;
        ly = pt + h + pb - maxp * step - side;
        lwx = lx - lx % step;
        lwy = ly - ly % step;
        words = 0;
        word_idx = 0;
        for (wy = 0; wy <= ly; wy += step)
            for (wx = 0; wx <= lx; wx += step)
                for (dd = 0; dd < d; dd++)
                    for (ky = 0; ky < side; ky++)
                        for (kx = 0; kx < side; kx++) begin
                            x = wx + kx;
                            y = wy + ky;
                            pad = (x < pl) || (x >= pl + w) || (y < pt) || (y >= pt + h);
                            addr = (dd * h + y - pt) * w + x - pl;
                            word = pad ? '0 : mem_copy[addr % MEM_WORDS];
                            last = (wy == lwy) && (wx == lwx) && (dd == d - 1) &&
                                   (ky == side - 1) && (kx == side - 1);
                            exp_q.push_back({last, word});
                            words++;
                        end
    endtask

    task automatic end_run(input int run);
        if (exp_q.size() != 0) begin
            $display("run %0d ended with %0d expected words never sent", run, exp_q.size());
            count_errors++;
            exp_q.delete();
        end
    endtask

    // rdy settles 1 ns after the edge, so the falling edge sees a stable handshake
    always @(negedge clk) begin
        if (rst_n && image_val && image_rdy) begin
            if (exp_q.size() == 0) begin
                $display("t=%0t extra word %h sent with no word expected", $time, image_bus);
                count_errors++;
            end else begin
                exp_word = exp_q.pop_front();
                if (image_bus !== exp_word[DW-1:0]) begin
                    $display("CHECK FAILED t=%0t word %0d: bus %h expected %h",
                             $time, word_idx, image_bus, exp_word[DW-1:0]);
                    value_errors++;
                end
                if (image_last !== exp_word[DW]) begin
                    $display("CHECK FAILED t=%0t word %0d: last %b expected %b",
                             $time, word_idx, image_last, exp_word[DW]);
                    value_errors++;
                end
                word_idx++;
            end
        end
    end

endmodule

// ==== test/image_reader_props.sv ====
/*
 * image reader properties
 * handshake hold, start timing and reset values, bound onto the top level
 */
`timescale 1ns/1ps

module image_reader_props #(
    parameter int DW = 64
) (
    input logic          clk,
    input logic          rst_n,
    input logic          next,
    input logic          busy,
    input logic          go,
    input logic          px_val,
    input logic          rd_val,
    input logic          image_val,
    input logic          image_rdy,
    input logic          image_last,
    input logic [DW-1:0] image_bus
);

    int unsigned prop_errors = 0;  // read back by the testbench summary

    // a stalled word keeps its value and flag
    hold_stall: assert property (@(posedge clk) disable iff (!rst_n)
        image_val && !image_rdy |=> image_val && $stable(image_bus) && $stable(image_last))
        else begin
            $error("stalled output word changed before transfer");
            prop_errors++;
        end

    // go follows an accepted next by 3 cycles
    go_timing: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> ##2 go)
        else begin
            $error("go missing 3 cycles after accepted next");
            prop_errors++;
        end

    // a next while busy starts nothing
    next_ignored: assert property (@(posedge clk) disable iff (!rst_n)
        next && busy |-> ##3 !go)
        else begin
            $error("next while busy produced a go");
            prop_errors++;
        end

    last_in_pass: assert property (@(posedge clk) disable iff (!rst_n)
        image_val && image_rdy && image_last |-> busy)
        else begin
            $error("last word transferred while not busy");
            prop_errors++;
        end

    in_reset: assert property (@(posedge clk)
        !rst_n |-> !image_val && !busy && !go && !px_val && !rd_val)
        else begin
            $error("control output high during reset");
            prop_errors++;
        end

endmodule

bind image_reader image_reader_props #(.DW(GROUP_NB * IMG_WIDTH)) i_props (
    .clk(clk), .rst_n(rst_n), .next(next), .busy(busy), .go(go),
    .px_val(px_val), .rd_val(rd_val), .image_val(image_val),
    .image_rdy(image_rdy), .image_last(image_last), .image_bus(image_bus)
);

// ==== test/tb_image_reader.sv ====
/*
 * image reader testbench
 * loads the image memory, runs fixed and random passes under optional
 * back-pressure and summarizes the checker and property results
 */
`timescale 1ns/1ps

module tb_image_reader;
    import image_read_pkg::*;

    localparam int GROUP_NB   = 4;
    localparam int IMG_WIDTH  = 16;
    localparam int MEM_AWIDTH = 10;
    localparam int RD_LATENCY = 3;
    localparam int FIFO_DEPTH = 8;
    localparam int DW         = GROUP_NB * IMG_WIDTH;
    localparam int MEM_WORDS  = 2**MEM_AWIDTH;

    logic clk, rst_n, cfg_valid, next, ld_en, image_rdy;
    logic [CFG_AWIDTH-1:0] cfg_addr;
    logic [CFG_DWIDTH-1:0] cfg_data;
    logic [MEM_AWIDTH-1:0] ld_addr;
    logic [DW-1:0]         ld_data, image_bus;
    logic image_val, image_last, busy;
    logic bp_en;                      // random back-pressure on image_rdy
    logic stuck;                      // a pass never finished, skip the rest
    int   seed, rdy_seed;
    int   cycle_cnt, cycle_limit;     // limit grows with every pass
    int   tb_errors, run_id;

    image_reader #(
        .GROUP_NB(GROUP_NB), .IMG_WIDTH(IMG_WIDTH), .MEM_AWIDTH(MEM_AWIDTH),
        .RD_LATENCY(RD_LATENCY), .FIFO_DEPTH(FIFO_DEPTH)
    ) i_dut (
        .clk(clk), .rst_n(rst_n), .cfg_valid(cfg_valid), .cfg_addr(cfg_addr),
        .cfg_data(cfg_data), .next(next), .ld_en(ld_en), .ld_addr(ld_addr),
        .ld_data(ld_data), .image_bus(image_bus), .image_val(image_val),
        .image_last(image_last), .image_rdy(image_rdy), .busy(busy)
    );

    image_reader_checker #(.DW(DW), .MEM_AWIDTH(MEM_AWIDTH)) i_checker (
        .clk(clk), .rst_n(rst_n), .image_val(image_val), .image_rdy(image_rdy),
        .image_last(image_last), .image_bus(image_bus)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        #1;
        image_rdy = bp_en ? (({$random(rdy_seed)} % 100) >= 40) : 1'b1;  // low ~40%
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    function automatic int rand_between(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    task automatic load_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            ld_en   = 1'b1;
            ld_addr = MEM_AWIDTH'(a);
            ld_data = DW'({$random(seed), $random(seed)});
            i_checker.note_word(a, ld_data);
            tick();
        end
        ld_en = 1'b0;
    endtask

    task automatic write_cfg(input logic [CFG_AWIDTH-1:0] addr,
                             input logic [CFG_DWIDTH-1:0] data);
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        tick();
        cfg_valid = 1'b0;
    endtask

    task automatic program_cfg(input int w, input int h, input int d, input int pl,
                               input int pr, input int pt, input int pb, input int maxp,
                               input int side, input int step);
        cfg_word_u word;
        write_cfg(cfg_ir_img_w, CFG_DWIDTH'(w - 1));
        word.dh.d = 16'(d - 1);
        word.dh.h = 16'(h - 1);
        write_cfg(cfg_ir_img_dh, word);
        word.pad.l = 8'(pl);
        word.pad.r = 8'(pr);
        word.pad.t = 8'(pt);
        word.pad.b = 8'(pb);
        write_cfg(cfg_ir_pad, word);
        word.conv.maxp_side = 8'(maxp);
        word.conv.conv_side = 8'(side - 1);
        word.conv.conv_step = 16'(step - 1);
        write_cfg(cfg_ir_conv, word);
    endtask

    // one pass, optionally with a second next while busy
    task automatic run_pass(input int w, input int h, input int d, input int pl,
                            input int pr, input int pt, input int pb, input int maxp,
                            input int side, input int step, input logic extra_next);
        int words, n;
        if (!stuck) begin
            run_id++;
            program_cfg(w, h, d, pl, pr, pt, pb, maxp, side, step);
            i_checker.expect_run(w, h, d, pl, pr, pt, pb, maxp, side, step, words);
            cycle_limit += words * 4 + 200;
            next = 1'b1;
            tick();
            next = 1'b0;
            if (extra_next) begin
                repeat (4) tick();
                if (busy) begin
                    next = 1'b1;
                    tick();
                    next = 1'b0;
                end
            end
            n = 0;
            while (busy && n < words * 4 + 150) begin
                tick();
                n++;
            end
            if (busy) begin
                $display("busy stuck high in run %0d after %0d cycles", run_id, n);
                tb_errors++;
                stuck = 1'b1;
            end else begin
                repeat (3) tick();  // catch late extra words
                i_checker.end_run(run_id);
            end
        end
    endtask

    task automatic random_pass();
        int w, h, d, pl, pr, pt, pb, maxp, side, step;
        do begin
            w    = rand_between(2, 5);
            h    = rand_between(2, 5);
            d    = rand_between(2, 3);
            pl   = rand_between(0, 2);
            pr   = rand_between(0, 2);
            pt   = rand_between(0, 2);
            pb   = rand_between(0, 2);
            maxp = rand_between(0, 1);
            side = rand_between(1, 3);
            step = rand_between(1, 2);
        end while (pl + w + pr < maxp * step + side || pt + h + pb < maxp * step + side);
        run_pass(w, h, d, pl, pr, pt, pb, maxp, side, step, 1'b1);
    endtask

    task automatic finish_test();
        int total;
        total = i_checker.value_errors + i_checker.count_errors + tb_errors
              + int'(i_dut.i_props.prop_errors);
        $display("errors: value %0d, word count %0d, control %0d, property %0d",
                 i_checker.value_errors, i_checker.count_errors, tb_errors,
                 i_dut.i_props.prop_errors);
        if (total == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    initial begin
        seed        = 32'h69f6;
        rdy_seed    = $random(seed);  // own stream for the rdy process
        clk         = 1'b0;
        rst_n       = 1'b0;
        cfg_valid   = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        next        = 1'b0;
        ld_en       = 1'b0;
        ld_addr     = '0;
        ld_data     = '0;
        image_rdy   = 1'b1;
        bp_en       = 1'b0;
        stuck       = 1'b0;
        cycle_cnt   = 0;
        cycle_limit = MEM_WORDS + 200;  // reset, idle check and memory load
        tb_errors   = 0;
        run_id      = 0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        if (image_val !== 1'b0 || busy !== 1'b0) begin
            $display("CHECK FAILED t=%0t: image_val %b busy %b after reset, expected 0",
                     $time, image_val, busy);
            tb_errors++;
        end
        repeat (20) tick();  // no next, so the checker must see no word
        load_memory();
        run_pass(4, 3, 2, 0, 0, 0, 0, 0, 1, 1, 1'b0);  // 1x1, raster order
        run_pass(5, 4, 2, 1, 1, 1, 1, 0, 3, 1, 1'b0);  // 3x3 padded all round
        run_pass(7, 6, 2, 0, 0, 0, 0, 1, 3, 2, 1'b0);  // step 2 with maxpool area
        bp_en = 1'b1;
        run_pass(5, 4, 2, 1, 1, 1, 1, 0, 3, 1, 1'b0);
        repeat (10) random_pass();
        finish_test();
    end

endmodule
